// ==== logic/fm_pkg.sv ====
package fm_pkg;

	// Slot geometry, six channels of four operators
	localparam int num_ch = 6;
	localparam int num_op = 4;
	localparam int num_slots = 24;
	localparam int slot_w = 5;

	// Timer B advances once every this many slot rounds
	localparam int timer_b_div = 16;

	// Register numbers as seen on the host port
	// Operator and channel entries are group base values,
	// the low bits carry the channel and operator fields
	typedef enum logic [7:0] {
		reg_lfo     = 8'h22,
		reg_clka1   = 8'h24,
		reg_clka2   = 8'h25,
		reg_clkb    = 8'h26,
		reg_timer   = 8'h27,
		reg_kon     = 8'h28,
		reg_dt_mul  = 8'h30,
		reg_tl      = 8'h40,
		reg_ks_ar   = 8'h50,
		reg_fnum_lo = 8'hA0,
		reg_fnum_hi = 8'hA4,
		reg_fb_alg  = 8'hB0
	} fm_reg_e;

	// Kinds of slot parameter update
	typedef enum logic [2:0] {
		// Per operator, target is one slot
		upd_dt_mul,
		upd_tl,
		upd_ks_ar,
		// Per channel, shared by the four operators
		upd_fnum,
		upd_fb_alg,
		// Operator mask for one channel, written at once
		upd_keyon
	} fm_upd_e;

endpackage

// ==== logic/fm_reg_decoder.sv ====
`timescale 1ns/1ps

module fm_reg_decoder (
	input  logic clk,
	input  logic rst,
	input  logic write,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	output logic busy,
	output logic lfo_en,
	output logic [2:0] lfo_freq,
	output logic [9:0] value_a,
	output logic [7:0] value_b,
	output logic load_a,
	output logic load_b,
	output logic stop_a,
	output logic stop_b,
	output logic en_irq_a,
	output logic en_irq_b,
	output logic clr_flag_a,
	output logic clr_flag_b,
	fm_update_if.issuer upd
);

	logic [7:0] sel_reg;
	logic [2:0] sel_ch;
	logic [1:0] sel_op;
	// Block and F-number high bits, waiting for the 0xA0 write
	logic [5:0] fnum_hi_latch;

	logic ch_ok;
	logic slot_hit;
	fm_pkg::fm_upd_e slot_kind;
	logic [2:0] kon_ch;

	// Field value 3 is not a channel
	assign ch_ok = sel_reg[1:0] != 2'b11;
	assign kon_ch = 3'(din[1:0]) + (din[2] ? 3'd3 : 3'd0);

	// Which selected numbers become slot updates
	always_comb begin
		slot_hit = ch_ok;
		slot_kind = fm_pkg::upd_dt_mul;
		if ({sel_reg[7:4], 4'h0} == fm_pkg::reg_dt_mul)
			slot_kind = fm_pkg::upd_dt_mul;
		else if ({sel_reg[7:4], 4'h0} == fm_pkg::reg_tl)
			slot_kind = fm_pkg::upd_tl;
		else if ({sel_reg[7:4], 4'h0} == fm_pkg::reg_ks_ar)
			slot_kind = fm_pkg::upd_ks_ar;
		else if ({sel_reg[7:2], 2'b00} == fm_pkg::reg_fnum_lo)
			slot_kind = fm_pkg::upd_fnum;
		else if ({sel_reg[7:2], 2'b00} == fm_pkg::reg_fb_alg)
			slot_kind = fm_pkg::upd_fb_alg;
		else
			slot_hit = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_reg <= 8'h00;
			sel_ch <= 3'd0;
			sel_op <= 2'd0;
			fnum_hi_latch <= 6'd0;
			busy <= 1'b0;
			upd.valid <= 1'b0;
			{lfo_en, lfo_freq} <= 4'd0;
			value_a <= 10'd0;
			value_b <= 8'd0;
			{load_a, load_b, stop_a, stop_b} <= 4'd0;
			{en_irq_a, en_irq_b, clr_flag_a, clr_flag_b} <= 4'd0;
		end else begin
			// Timer control pulses last one cycle
			{load_a, load_b, stop_a, stop_b} <= 4'd0;
			{clr_flag_a, clr_flag_b} <= 2'd0;

			if (upd.valid) begin
				if (upd.done) begin
					upd.valid <= 1'b0;
					busy <= 1'b0;
				end
			end else begin
				busy <= 1'b0;
			end

			if (write && !busy) begin
				if (!addr[0]) begin
					sel_reg <= din;
					sel_ch <= 3'(din[1:0]) + (addr[1] ? 3'd3 : 3'd0);
					// Chip order S1 S3 S2 S4
					sel_op <= {din[2], din[3]};
				end else begin
					busy <= 1'b1;
					if (sel_reg == fm_pkg::reg_kon) begin
						if (din[1:0] != 2'b11) begin
							upd.valid <= 1'b1;
							upd.kind <= fm_pkg::upd_keyon;
							upd.ch <= kon_ch;
							upd.op <= 2'd0;
							upd.data <= {12'h000, din[7:4]};
						end
					end else if (slot_hit) begin
						upd.valid <= 1'b1;
						upd.kind <= slot_kind;
						upd.ch <= sel_ch;
						upd.op <= sel_op;
						upd.data <= (slot_kind == fm_pkg::upd_fnum) ?
							{2'b00, fnum_hi_latch, din} : {8'h00, din};
					end else if ({sel_reg[7:2], 2'b00} == fm_pkg::reg_fnum_hi) begin
						if (ch_ok)
							fnum_hi_latch <= din[5:0];
					end else begin
						case (sel_reg)
							fm_pkg::reg_lfo: {lfo_en, lfo_freq} <= din[3:0];
							fm_pkg::reg_clka1: value_a[9:2] <= din;
							fm_pkg::reg_clka2: value_a[1:0] <= din[1:0];
							fm_pkg::reg_clkb: value_b <= din;
							fm_pkg::reg_timer: begin
								load_a <= din[0];
								stop_a <= ~din[0];
								load_b <= din[1];
								stop_b <= ~din[1];
								{en_irq_b, en_irq_a} <= din[3:2];
								{clr_flag_b, clr_flag_a} <= din[5:4];
							end
							default: ;
						endcase
					end
				end
			end
		end
	end

	// Updates only run under busy, so the host cannot stack a second one
	assert property (@(posedge clk) disable iff (rst) upd.valid |-> busy);

	assert property (@(posedge clk) disable iff (rst)
		upd.valid |=> !upd.valid || $stable({upd.kind, upd.ch, upd.op, upd.data}));

endmodule

// ==== logic/fm_regs_top.sv ====
`timescale 1ns/1ps

module fm_regs_top (
	input  logic clk,
	input  logic rst,
	input  logic write,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	output logic busy,
	output logic irq_n,
	output logic flag_a,
	output logic flag_b,
	output logic lfo_en,
	output logic [2:0] lfo_freq,
	output logic [2:0] slot_ch,
	output logic [1:0] slot_op,
	output logic [3:0] mul,
	output logic [2:0] dt,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic [10:0] fnum,
	output logic [2:0] block,
	output logic [2:0] fb,
	output logic [2:0] alg,
	output logic keyon
);

	logic [9:0] value_a;
	logic [7:0] value_b;
	logic load_a, load_b, stop_a, stop_b;
	logic en_irq_a, en_irq_b, clr_flag_a, clr_flag_b;
	logic round_start;

	fm_update_if upd_if ();

	fm_reg_decoder fm_reg_decoder_inst (
		.clk(clk), .rst(rst), .write(write), .addr(addr), .din(din),
		.busy(busy), .lfo_en(lfo_en), .lfo_freq(lfo_freq),
		.value_a(value_a), .value_b(value_b),
		.load_a(load_a), .load_b(load_b), .stop_a(stop_a), .stop_b(stop_b),
		.en_irq_a(en_irq_a), .en_irq_b(en_irq_b),
		.clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b),
		.upd(upd_if.issuer)
	);

	fm_slot_regs fm_slot_regs_inst (
		.clk(clk), .rst(rst), .upd(upd_if.sink),
		.round_start(round_start), .slot_ch(slot_ch), .slot_op(slot_op),
		.mul(mul), .dt(dt), .tl(tl), .ks(ks), .ar(ar),
		.fnum(fnum), .block(block), .fb(fb), .alg(alg), .keyon(keyon)
	);

	fm_timers fm_timers_inst (
		.clk(clk), .rst(rst), .round_start(round_start),
		.value_a(value_a), .value_b(value_b),
		.load_a(load_a), .load_b(load_b), .stop_a(stop_a), .stop_b(stop_b),
		.en_irq_a(en_irq_a), .en_irq_b(en_irq_b),
		.clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b),
		.flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
	);

endmodule

// ==== logic/fm_slot_regs.sv ====
`timescale 1ns/1ps

module fm_slot_regs (
	input  logic clk,
	input  logic rst,
	fm_update_if.sink upd,
	output logic round_start,
	output logic [2:0] slot_ch,
	output logic [1:0] slot_op,
	output logic [3:0] mul,
	output logic [2:0] dt,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic [10:0] fnum,
	output logic [2:0] block,
	output logic [2:0] fb,
	output logic [2:0] alg,
	output logic keyon
);

	logic [fm_pkg::slot_w-1:0] slot;

	// Operator storage, indexed by slot = op * 6 + ch
	logic [6:0] dt_mul_mem [fm_pkg::num_slots];
	logic [6:0] tl_mem [fm_pkg::num_slots];
	logic [6:0] ks_ar_mem [fm_pkg::num_slots];
	logic keyon_mem [fm_pkg::num_slots];

	// Channel storage
	logic [13:0] fnum_mem [fm_pkg::num_ch];
	logic [5:0] fb_alg_mem [fm_pkg::num_ch];

	logic ch_hit;
	logic op_hit;

	assign slot_ch = 3'(slot % fm_pkg::num_ch);
	assign slot_op = 2'(slot / fm_pkg::num_ch);
	assign round_start = slot == '0;

	assign ch_hit = slot_ch == upd.ch;
	assign op_hit = ch_hit && slot_op == upd.op;

	// Parameters of the current slot
	assign {dt, mul} = dt_mul_mem[slot];
	assign tl = tl_mem[slot];
	assign {ks, ar} = ks_ar_mem[slot];
	assign keyon = keyon_mem[slot];
	assign {block, fnum} = fnum_mem[slot_ch];
	assign {fb, alg} = fb_alg_mem[slot_ch];

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
			upd.done <= 1'b0;
			for (int i = 0; i < fm_pkg::num_slots; i++) begin
				dt_mul_mem[i] <= 7'd0;
				tl_mem[i] <= 7'd0;
				ks_ar_mem[i] <= 7'd0;
				keyon_mem[i] <= 1'b0;
			end
			for (int i = 0; i < fm_pkg::num_ch; i++) begin
				fnum_mem[i] <= 14'd0;
				fb_alg_mem[i] <= 6'd0;
			end
		end else begin
			slot <= (slot == fm_pkg::slot_w'(fm_pkg::num_slots - 1)) ? '0 : slot + 1'b1;
			upd.done <= 1'b0;
			// Skip the done cycle, valid is still up then
			if (upd.valid && !upd.done) begin
				case (upd.kind)
					fm_pkg::upd_dt_mul: if (op_hit) begin
						dt_mul_mem[slot] <= upd.data[6:0];
						upd.done <= 1'b1;
					end
					fm_pkg::upd_tl: if (op_hit) begin
						tl_mem[slot] <= upd.data[6:0];
						upd.done <= 1'b1;
					end
					fm_pkg::upd_ks_ar: if (op_hit) begin
						// KS in bits 7:6, AR in bits 4:0
						ks_ar_mem[slot] <= {upd.data[7:6], upd.data[4:0]};
						upd.done <= 1'b1;
					end
					fm_pkg::upd_fnum: if (ch_hit) begin
						fnum_mem[slot_ch] <= upd.data[13:0];
						upd.done <= 1'b1;
					end
					fm_pkg::upd_fb_alg: if (ch_hit) begin
						fb_alg_mem[slot_ch] <= upd.data[5:0];
						upd.done <= 1'b1;
					end
					fm_pkg::upd_keyon: begin
						for (int o = 0; o < fm_pkg::num_op; o++)
							keyon_mem[o * fm_pkg::num_ch + int'(upd.ch)] <= upd.data[o];
						upd.done <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) upd.done |-> upd.valid);

endmodule

// ==== logic/fm_timers.sv ====
`timescale 1ns/1ps

module fm_timers (
	input  logic clk,
	input  logic rst,
	input  logic round_start,
	input  logic [9:0] value_a,
	input  logic [7:0] value_b,
	input  logic load_a,
	input  logic load_b,
	input  logic stop_a,
	input  logic stop_b,
	input  logic en_irq_a,
	input  logic en_irq_b,
	input  logic clr_flag_a,
	input  logic clr_flag_b,
	output logic flag_a,
	output logic flag_b,
	output logic irq_n
);

	logic run_a;
	logic run_b;
	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [$clog2(fm_pkg::timer_b_div)-1:0] div_b;
	logic tick_b;

	// Timer B prescaler over slot rounds
	assign tick_b = round_start && (int'(div_b) == fm_pkg::timer_b_div - 1);

	assign irq_n = !(flag_a || flag_b);

	always_ff @(posedge clk) begin
		if (rst) begin
			{run_a, run_b} <= 2'b00;
			cnt_a <= 10'd0;
			cnt_b <= 8'd0;
			div_b <= '0;
			{flag_a, flag_b} <= 2'b00;
		end else begin
			if (round_start)
				div_b <= tick_b ? '0 : div_b + 1'b1;

			if (load_a) begin
				cnt_a <= value_a;
				run_a <= 1'b1;
			end else if (stop_a) begin
				run_a <= 1'b0;
			end else if (run_a && round_start) begin
				if (cnt_a == 10'h3ff) begin
					cnt_a <= value_a;
					if (en_irq_a)
						flag_a <= 1'b1;
				end else begin
					cnt_a <= cnt_a + 1'b1;
				end
			end

			if (load_b) begin
				cnt_b <= value_b;
				run_b <= 1'b1;
				div_b <= '0;
			end else if (stop_b) begin
				run_b <= 1'b0;
			end else if (run_b && tick_b) begin
				if (cnt_b == 8'hff) begin
					cnt_b <= value_b;
					if (en_irq_b)
						flag_b <= 1'b1;
				end else begin
					cnt_b <= cnt_b + 1'b1;
				end
			end

			// Host clear wins over a same-cycle overflow
			if (clr_flag_a)
				flag_a <= 1'b0;
			if (clr_flag_b)
				flag_b <= 1'b0;
		end
	end

	// A flag only rises on an overflow of a running timer with its irq enabled
	assert property (@(posedge clk) disable iff (rst)
		$rose(flag_a) |-> $past(en_irq_a && run_a && round_start && cnt_a == 10'h3ff));

	assert property (@(posedge clk) disable iff (rst)
		$rose(flag_b) |-> $past(en_irq_b && run_b && tick_b && cnt_b == 8'hff));

endmodule

// ==== logic/fm_update_if.sv ====
`timescale 1ns/1ps

// One pending parameter update, decoder to slot register file
interface fm_update_if;
	logic valid;
	fm_pkg::fm_upd_e kind;
	logic [2:0] ch;
	logic [1:0] op;
	logic [15:0] data;
	// One cycle pulse once the target slot has been written
	logic done;

	modport issuer (
		output valid, kind, ch, op, data,
		input  done
	);

	modport sink (
		input  valid, kind, ch, op, data,
		output done
	);
endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module fm_regs_tb -f vlog.f
./obj_dir/Vfm_regs_tb > sim.log 2>&1
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi

// ==== verification/fm_regs_tb.sv ====
`timescale 1ns/1ps

module fm_regs_tb;

	logic clk;
	logic rst;
	logic write;
	logic [1:0] addr;
	logic [7:0] din;
	logic busy, irq_n, flag_a, flag_b, lfo_en, keyon;
	logic [2:0] lfo_freq, slot_ch, dt, block, fb, alg;
	logic [1:0] slot_op, ks;
	logic [3:0] mul;
	logic [6:0] tl;
	logic [4:0] ar;
	logic [10:0] fnum;

	// Expected parameters with slots indexed op * 6 + ch
	int exp_dt [24];
	int exp_mul [24];
	int exp_tl [24];
	int exp_ks [24];
	int exp_ar [24];
	int exp_keyon [24];
	int exp_fnum [6];
	int exp_block [6];
	int exp_fb [6];
	int exp_alg [6];
	int hi_latch;
	int errors;
	int checks;

	fm_regs_top fm_regs_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic compare(input string name, input int got, input int want);
		checks++;
		assert (got == want) else begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
			errors++;
		end
	endtask

	// Rising edge plus the drive offset
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < 50) begin
			step();
			n++;
		end
		if (busy) begin
			$display("Timeout at %0t ns: busy stayed high for 50 cycles", $time);
			errors++;
		end
	endtask

	// Register select step and then the data step
	task automatic host_write(input logic bank, input logic [7:0] num, input logic [7:0] data);
		wait_idle();
		write = 1'b1;
		addr = {bank, 1'b0};
		din = num;
		step();
		addr = {bank, 1'b1};
		din = data;
		step();
		write = 1'b0;
	endtask

	task automatic op_write(input int base, input int ch, input int op, input int data);
		int field;
		int s;
		// Register field order is S1 S3 S2 S4
		field = (op == 1) ? 2 : (op == 2) ? 1 : op;
		s = op * 6 + ch;
		host_write(ch >= 3, 8'(base + field * 4 + ch % 3), 8'(data));
		if (base == 'h30) begin
			exp_dt[s] = (data >> 4) & 7;
			exp_mul[s] = data & 15;
		end else if (base == 'h40) begin
			exp_tl[s] = data & 127;
		end else begin
			exp_ks[s] = (data >> 6) & 3;
			exp_ar[s] = data & 31;
		end
	endtask

	task automatic chan_write(input int base, input int ch, input int data);
		host_write(ch >= 3, 8'(base + ch % 3), 8'(data));
		if (base == 'hA4) begin
			hi_latch = data & 63;
		end else if (base == 'hA0) begin
			exp_block[ch] = hi_latch >> 3;
			exp_fnum[ch] = (hi_latch & 7) * 256 + data;
		end else begin
			exp_fb[ch] = (data >> 3) & 7;
			exp_alg[ch] = data & 7;
		end
	endtask

	task automatic key_on(input int ch, input int mask);
		host_write(1'b0, 8'h28, 8'(mask * 16 + (ch >= 3 ? 4 : 0) + ch % 3));
		for (int o = 0; o < 4; o++)
			exp_keyon[o * 6 + ch] = (mask >> o) & 1;
	endtask

	task automatic check_slot(input int ch, input int op);
		int n;
		int s;
		n = 0;
		s = op * 6 + ch;
		while ((int'(slot_ch) != ch || int'(slot_op) != op) && n < 30) begin
			step();
			n++;
		end
		if (int'(slot_ch) != ch || int'(slot_op) != op) begin
			$display("Timeout at %0t ns: slot of channel %0d operator %0d never came round",
				$time, ch, op);
			errors++;
		end else begin
			compare("dt", int'(dt), exp_dt[s]);
			compare("mul", int'(mul), exp_mul[s]);
			compare("tl", int'(tl), exp_tl[s]);
			compare("ks", int'(ks), exp_ks[s]);
			compare("ar", int'(ar), exp_ar[s]);
			compare("keyon", int'(keyon), exp_keyon[s]);
			compare("fnum", int'(fnum), exp_fnum[ch]);
			compare("block", int'(block), exp_block[ch]);
			compare("fb", int'(fb), exp_fb[ch]);
			compare("alg", int'(alg), exp_alg[ch]);
		end
	endtask

	// One full round in counter order
	task automatic check_all();
		wait_idle();
		for (int s = 0; s < 24; s++)
			check_slot(s % 6, s / 6);
	endtask

	task automatic test_timers();
		int n;
		host_write(1'b0, 8'h24, 8'hff);
		host_write(1'b0, 8'h25, 8'h01);
		host_write(1'b0, 8'h26, 8'hfe);
		// Start both timers with irq A only
		host_write(1'b0, 8'h27, 8'h07);
		n = 0;
		while (irq_n && n < 4 * 24 + 10) begin
			step();
			n++;
		end
		if (irq_n) begin
			$display("Timeout at %0t ns: timer A raised no interrupt in 4 rounds", $time);
			errors++;
		end
		compare("flag_a", int'(flag_a), 1);
		compare("flag_b", int'(flag_b), 0);
		// Stop A and clear its flag while B restarts
		host_write(1'b0, 8'h27, 8'h12);
		step();
		compare("irq_n", int'(irq_n), 1);
		n = 0;
		repeat (40 * 24) begin
			if (!irq_n || flag_b)
				n++;
			step();
		end
		compare("irq_n low cycles", n, 0);
	endtask

	task automatic test_busy();
		int n;
		op_write('h40, 1, 3, 'h2a);
		compare("busy", int'(busy), 1);
		// Second TL data step while the update is pending
		write = 1'b1;
		addr = 2'b01;
		din = 8'h55;
		step();
		write = 1'b0;
		check_all();
		host_write(1'b0, 8'h23, 8'h5a);
		n = 0;
		while (busy && n < 10) begin
			n++;
			step();
		end
		compare("busy cycles", n, 1);
	endtask

	initial begin
		int e0;
		rst = 1'b1;
		write = 1'b0;
		addr = 2'b00;
		din = 8'h00;
		errors = 0;
		checks = 0;
		hi_latch = 0;
		for (int i = 0; i < 24; i++) begin
			exp_dt[i] = 0;
			exp_mul[i] = 0;
			exp_tl[i] = 0;
			exp_ks[i] = 0;
			exp_ar[i] = 0;
			exp_keyon[i] = 0;
		end
		for (int i = 0; i < 6; i++) begin
			exp_fnum[i] = 0;
			exp_block[i] = 0;
			exp_fb[i] = 0;
			exp_alg[i] = 0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		e0 = errors;
		compare("busy", int'(busy), 0);
		compare("irq_n", int'(irq_n), 1);
		compare("flag_a", int'(flag_a), 0);
		compare("flag_b", int'(flag_b), 0);
		compare("lfo_en", int'(lfo_en), 0);
		compare("lfo_freq", int'(lfo_freq), 0);
		check_all();
		$display("Reset state: %0d errors", errors - e0);

		e0 = errors;
		op_write('h40, 0, 1, 'h15);
		op_write('h30, 0, 1, 'h73);
		op_write('h50, 0, 1, 'hc9);
		op_write('h40, 4, 2, 'h7f);
		op_write('h30, 5, 3, 'h21);
		op_write('h50, 3, 0, 'h5f);
		op_write('h30, 2, 2, 'h4e);
		check_all();
		$display("Operator registers: %0d errors", errors - e0);

		e0 = errors;
		chan_write('hA4, 4, 'h2d);
		chan_write('hA0, 4, 'h9c);
		chan_write('hB0, 4, 'h1e);
		check_all();
		$display("Channel registers: %0d errors", errors - e0);

		e0 = errors;
		key_on(2, 'h5);
		check_all();
		$display("Key-on: %0d errors", errors - e0);

		e0 = errors;
		// Bit 3 enables the LFO and bits 2:0 pick its rate
		host_write(1'b0, 8'h22, 8'h0d);
		compare("lfo_en", int'(lfo_en), 1);
		compare("lfo_freq", int'(lfo_freq), 5);
		$display("LFO register: %0d errors", errors - e0);

		e0 = errors;
		test_timers();
		$display("Timers: %0d errors", errors - e0);

		e0 = errors;
		test_busy();
		$display("Busy and dropped writes: %0d errors", errors - e0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/fm_pkg.sv
logic/fm_update_if.sv
logic/fm_reg_decoder.sv
logic/fm_slot_regs.sv
logic/fm_timers.sv
logic/fm_regs_top.sv
verification/fm_regs_tb.sv
